//--- common/fb_pkg.sv
`default_nettype none

package fb_pkg;

    // visible area and porches, in pixel clocks
    localparam int h_disp  = 16;
    localparam int h_fp    = 2;
    localparam int h_sync  = 3;
    localparam int h_bp    = 3;
    localparam int h_total = h_disp + h_fp + h_sync + h_bp;  // 24

    // vertical timing, in lines
    localparam int v_disp  = 8;
    localparam int v_fp    = 1;
    localparam int v_sync  = 2;
    localparam int v_bp    = 1;
    localparam int v_total = v_disp + v_fp + v_sync + v_bp;  // 12

    localparam int fb_depth = h_disp * v_disp;  // one pixel per word

    localparam int addr_w = 7;  // log2 of fb_depth
    localparam int cnt_w  = 5;  // holds h_total - 1 and v_total - 1
    localparam int len_w  = 8;

    // command coordinates only reach the visible area
    localparam int x_w = $clog2(h_disp);
    localparam int y_w = $clog2(v_disp);

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // one horizontal run of a single colour
    typedef struct packed {
        logic [x_w-1:0]   x;
        logic [y_w-1:0]   y;
        logic [len_w-1:0] len;  // zero is rejected
        pixel_t           color;
    } draw_cmd_t;

    // frame RAM write port
    typedef struct packed {
        logic              en;
        logic [addr_w-1:0] addr;
        pixel_t            data;
    } fb_wr_t;

    // raster position plus its decoded strobes
    typedef struct packed {
        logic [cnt_w-1:0] hcount;
        logic [cnt_w-1:0] vcount;
        logic             de;
        logic             hsync;
        logic             vsync;
    } raster_t;

    // pixel stream toward the HDMI encoder
    typedef struct packed {
        pixel_t rgb;
        logic   de;
        logic   hsync;
        logic   vsync;
    } video_t;

endpackage

`default_nettype wire

//--- logic/video_timing.sv
`default_nettype none

module video_timing (
    input  logic            clk,
    input  logic            rst_n,
    output fb_pkg::raster_t raster
);
    import fb_pkg::*;

    logic [cnt_w-1:0] h_nxt;
    logic [cnt_w-1:0] v_nxt;

    // strobes for a given position, so they stay aligned with the counters
    function automatic raster_t decode(input logic [cnt_w-1:0] h, input logic [cnt_w-1:0] v);
        raster_t res;
        res.hcount = h;
        res.vcount = v;
        res.de     = (h < cnt_w'(h_disp)) && (v < cnt_w'(v_disp));
        res.hsync  = (h >= cnt_w'(h_disp + h_fp)) && (h < cnt_w'(h_disp + h_fp + h_sync));
        res.vsync  = (v >= cnt_w'(v_disp + v_fp)) && (v < cnt_w'(v_disp + v_fp + v_sync));
        return res;
    endfunction

    always_comb
    begin
        h_nxt = raster.hcount + 1'b1;
        v_nxt = raster.vcount;
        if (raster.hcount == cnt_w'(h_total - 1))
        begin
            h_nxt = '0;
            if (raster.vcount == cnt_w'(v_total - 1))
                v_nxt = '0;  // end of frame
            else
                v_nxt = raster.vcount + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            raster <= decode('0, '0);
        else
            raster <= decode(h_nxt, v_nxt);
    end

    // sync sits in the blanking interval only
    a_hsync_not_de: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(raster.hsync && raster.de)
    );

endmodule

`default_nettype wire

//--- logic/draw_engine.sv
`default_nettype none

module draw_engine (
    input  logic              clk,
    input  logic              rst_n,
    input  fb_pkg::draw_cmd_t cmd,
    input  logic              cmd_valid,
    input  logic              ready,
    output logic              busy,
    output logic              done,
    output fb_pkg::fb_wr_t    fb_wr
);
    import fb_pkg::*;

    typedef enum logic {
        st_idle,
        st_run
    } state_t;

    state_t            state;
    logic [len_w-1:0]  remaining;   // writes left, including the current one
    logic              accept;
    logic [addr_w-1:0] start_addr;
    logic              wr_en;
    logic [addr_w-1:0] wr_addr;
    pixel_t            wr_color;

    // strobes while busy or before the RAM is cleared are simply lost
    assign accept = cmd_valid && ready && (state == st_idle) && (cmd.len != '0);

    assign start_addr = addr_w'(cmd.y) * addr_w'(h_disp) + addr_w'(cmd.x);

    assign busy = (state == st_run);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= st_idle;
            remaining <= '0;
            wr_en     <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (accept)
                    begin
                        state     <= st_run;
                        remaining <= cmd.len;
                        wr_en     <= 1'b1;  // first write lands with busy
                    end
                end
                st_run:
                begin
                    if (remaining == len_w'(1))
                    begin
                        state <= st_idle;
                        wr_en <= 1'b0;
                        done  <= 1'b1;  // falls together with busy
                    end
                    else
                        remaining <= remaining - 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            wr_addr  <= start_addr;
            wr_color <= cmd.color;
        end
        else if (state == st_run)
        begin
            if (wr_addr == addr_w'(fb_depth - 1))
                wr_addr <= '0;  // run continues at top of frame
            else
                wr_addr <= wr_addr + 1'b1;
        end
    end

    assign fb_wr = '{en: wr_en, addr: wr_addr, data: wr_color};

    a_wr_in_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        fb_wr.en |-> busy
    );

    a_done_after_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> (!busy && $past(busy))
    );

endmodule

`default_nettype wire

//--- framebuf/frame_ram.sv
`default_nettype none

module frame_ram (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fb_pkg::fb_wr_t            fb_wr,
    input  logic [fb_pkg::addr_w-1:0] rd_addr,
    output fb_pkg::pixel_t            rd_data,
    output logic                      ready
);
    import fb_pkg::*;

    pixel_t            mem [fb_depth];
    logic [addr_w-1:0] clr_addr;
    logic              we;
    logic [addr_w-1:0] waddr;
    pixel_t            wdata;

    // clear walks every word once, then hands the port to the engine
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clr_addr <= '0;
            ready    <= 1'b0;
        end
        else if (!ready)
        begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == addr_w'(fb_depth - 1))
                ready <= 1'b1;  // stays high until next reset
        end
    end

    always_comb
    begin
        if (ready)
        begin
            we    = fb_wr.en;
            waddr = fb_wr.addr;
            wdata = fb_wr.data;
        end
        else
        begin
            we    = 1'b1;
            waddr = clr_addr;
            wdata = '0;
        end
    end

    // read returns the old word when both ports hit the same address
    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
        rd_data <= mem[rd_addr];
    end

    a_no_wr_during_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        fb_wr.en |-> ready
    );

endmodule

`default_nettype wire

//--- logic/scanout.sv
`default_nettype none

module scanout (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fb_pkg::raster_t           raster,
    output logic [fb_pkg::addr_w-1:0] rd_addr,
    input  fb_pkg::pixel_t            rd_data,
    output fb_pkg::video_t            video
);
    import fb_pkg::*;

    logic de_q;
    logic hsync_q;
    logic vsync_q;

    // row-major frame, address only meaningful inside the visible area
    always_comb
    begin
        if (raster.de)
            rd_addr = addr_w'(raster.vcount) * addr_w'(h_disp) + addr_w'(raster.hcount);
        else
            rd_addr = '0;
    end

    // one stage to match the registered RAM read
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            de_q    <= 1'b0;
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
        end
        else
        begin
            de_q    <= raster.de;
            hsync_q <= raster.hsync;
            vsync_q <= raster.vsync;
        end
    end

    assign video.rgb   = de_q ? rd_data : '0;  // black in blanking
    assign video.de    = de_q;
    assign video.hsync = hsync_q;
    assign video.vsync = vsync_q;

endmodule

`default_nettype wire

//--- logic/display_top.sv
`default_nettype none

module display_top (
    input  logic              clk,
    input  logic              rst_n,
    input  fb_pkg::draw_cmd_t cmd,
    input  logic              cmd_valid,
    output logic              busy,
    output logic              done,
    output logic              ready,
    output fb_pkg::video_t    video
);
    import fb_pkg::*;

    fb_wr_t            fb_wr;    // engine to RAM
    raster_t           raster;   // timing to scanout
    logic [addr_w-1:0] rd_addr;
    pixel_t            rd_data;

    video_timing u_video_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .raster (raster)
    );

    draw_engine u_draw_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .ready     (ready),
        .busy      (busy),
        .done      (done),
        .fb_wr     (fb_wr)
    );

    frame_ram u_frame_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .fb_wr   (fb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .ready   (ready)
    );

    scanout u_scanout (
        .clk     (clk),
        .rst_n   (rst_n),
        .raster  (raster),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .video   (video)
    );

endmodule

`default_nettype wire

//--- sim/tb_display_top.sv
`default_nettype none

module tb_display_top;
    import fb_pkg::*;

    typedef struct packed {
        draw_cmd_t cmd;
        logic      accept;  // handshake should take it
        logic      poke;    // strobe a second command mid-run
    } stim_t;

    localparam int n_entries     = 10;
    localparam int watchdog_time = (n_entries + 2) * 2 * h_total * v_total * 4;

    logic      clk = 1'b0;
    logic      rst_n;
    draw_cmd_t cmd;
    logic      cmd_valid;
    logic      busy;
    logic      done;
    logic      ready;
    video_t    video;

    stim_t       stim [n_entries];
    pixel_t      model [fb_depth];  // expected frame contents
    draw_cmd_t   poke_cmd;
    logic [31:0] rng = 32'h3cf7;
    int          errors = 0;
    int          checks = 0;

    display_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .busy      (busy),
        .done      (done),
        .ready     (ready),
        .video     (video)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic pixel_t next_color();
        rng = xorshift(rng);
        return rng[23:0];
    endfunction

    function automatic draw_cmd_t make_cmd(input logic [x_w-1:0] x, input logic [y_w-1:0] y,
                                           input logic [len_w-1:0] len, input pixel_t color);
        draw_cmd_t c;
        c.x     = x;
        c.y     = y;
        c.len   = len;
        c.color = color;
        return c;
    endfunction

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error: t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("error: t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // one clock, inputs change just after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_strobe(input draw_cmd_t c);
        cmd       = c;
        cmd_valid = 1'b1;
        step();
        cmd_valid = 1'b0;
    endtask

    // row-major run, wraps at the end of the frame
    task automatic apply_to_model(input draw_cmd_t c);
        int start;
        start = int'(c.x) + int'(c.y) * h_disp;
        for (int i = 0; i < int'(c.len); i++)
            model[addr_w'((start + i) % fb_depth)] = c.color;
    endtask

    task automatic run_accepted(input draw_cmd_t c, input logic poke);
        int busy_cnt;
        busy_cnt = 0;
        drive_strobe(c);
        while (busy)
        begin
            check_bit("done", done, 1'b0);
            busy_cnt++;
            if (poke && busy_cnt == 2)
            begin
                cmd       = poke_cmd;  // must be dropped
                cmd_valid = 1'b1;
            end
            step();
            cmd_valid = 1'b0;
        end
        check_bit("done", done, 1'b1);
        check_count("busy cycles", busy_cnt, int'(c.len));
        step();
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
    endtask

    task automatic run_rejected(input draw_cmd_t c);
        drive_strobe(c);
        for (int k = 0; k < 4; k++)
        begin
            check_bit("busy", busy, 1'b0);
            check_bit("done", done, 1'b0);
            step();
        end
    endtask

    task automatic wait_vsync_fall();
        while (!video.vsync)
            step();
        while (video.vsync)
            step();
    endtask

    // window starts on the back porch line right after vsync
    task automatic check_frame();
        int   h;
        int   v;
        int   de_cnt;
        int   hs_cnt;
        int   vs_cnt;
        logic exp_de;
        logic exp_hs;
        logic exp_vs;
        de_cnt = 0;
        hs_cnt = 0;
        vs_cnt = 0;
        for (int i = 0; i < h_total * v_total; i++)
        begin
            h = i % h_total;
            v = (i / h_total == 0) ? v_total - 1 : i / h_total - 1;
            exp_de = (h < h_disp) && (v < v_disp);
            exp_hs = (h >= h_disp + h_fp) && (h < h_disp + h_fp + h_sync);
            exp_vs = (v >= v_disp + v_fp) && (v < v_disp + v_fp + v_sync);
            check_bit("de", video.de, exp_de);
            check_bit("hsync", video.hsync, exp_hs);
            check_bit("vsync", video.vsync, exp_vs);
            if (video.de)
                de_cnt++;
            if (exp_de)
                check_pixel($sformatf("rgb at x=%0d y=%0d", h, v), video.rgb,
                            model[addr_w'(v * h_disp + h)]);
            else
                check_pixel("rgb in blanking", video.rgb, '0);
            if (video.hsync)
                hs_cnt++;
            if (video.vsync)
                vs_cnt++;
            if (h == h_total - 1)
            begin
                check_count("hsync cycles in line", hs_cnt, h_sync);
                hs_cnt = 0;
            end
            step();
        end
        check_count("de cycles in frame", de_cnt, h_disp * v_disp);
        check_count("vsync cycles in frame", vs_cnt, v_sync * h_total);
    endtask

    initial
    begin
        int ready_cycles;
        rst_n     = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        for (int i = 0; i < fb_depth; i++)
            model[addr_w'(i)] = '0;

        poke_cmd = make_cmd(4'd0, 3'd0, 8'd40, 24'hffffff);
        stim[0] = '{make_cmd(4'd0, 3'd0, 8'd16, 24'hff0000), 1'b1, 1'b0};  // whole first line
        stim[1] = '{make_cmd(4'd4, 3'd2, 8'd8, next_color()), 1'b1, 1'b0};
        stim[2] = '{make_cmd(4'd6, 3'd2, 8'd3, next_color()), 1'b1, 1'b0};  // inside entry 1
        stim[3] = '{make_cmd(4'd0, 3'd3, 8'd0, next_color()), 1'b0, 1'b0};  // zero length
        stim[4] = '{make_cmd(4'd10, 3'd7, 8'd12, next_color()), 1'b1, 1'b0};  // wraps to 0
        stim[5] = '{make_cmd(4'd2, 3'd5, 8'd20, 24'h00ff00), 1'b1, 1'b1};
        stim[6] = '{make_cmd(4'd0, 3'd1, 8'd1, next_color()), 1'b1, 1'b0};
        stim[7] = '{make_cmd(4'd15, 3'd4, 8'd2, 24'h0000ff), 1'b1, 1'b0};  // crosses a line
        stim[8] = '{make_cmd(4'd3, 3'd6, 8'd0, 24'hffffff), 1'b0, 1'b0};
        stim[9] = '{make_cmd(4'd8, 3'd5, 8'd5, next_color()), 1'b1, 1'b0};

        repeat (3) @(posedge clk);
        #1;
        check_bit("ready", ready, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_pixel("rgb", video.rgb, '0);
        check_bit("de", video.de, 1'b0);
        check_bit("hsync", video.hsync, 1'b0);
        check_bit("vsync", video.vsync, 1'b0);
        rst_n = 1'b1;

        // strobe during the clear is lost
        drive_strobe(poke_cmd);
        ready_cycles = 1;
        check_bit("ready", ready, 1'b0);
        check_bit("busy", busy, 1'b0);
        while (!ready)
        begin
            step();
            ready_cycles++;
            check_bit("busy", busy, 1'b0);
        end
        check_count("cycles until ready", ready_cycles, fb_depth);
        wait_vsync_fall();
        check_frame();

        for (int n = 0; n < n_entries; n++)
        begin
            check_bit("ready", ready, 1'b1);
            if (stim[n].accept)
            begin
                apply_to_model(stim[n].cmd);
                run_accepted(stim[n].cmd, stim[n].poke);
            end
            else
                run_rejected(stim[n].cmd);
            wait_vsync_fall();
            check_frame();
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        #(watchdog_time);
        $display("timeout: test sequence still running after %0d time units", watchdog_time);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
common/fb_pkg.sv
logic/video_timing.sv
logic/draw_engine.sv
framebuf/frame_ram.sv
logic/scanout.sv
logic/display_top.sv
sim/tb_display_top.sv

//--- Makefile
# Verilator build for the frame-buffer display subsystem

VERILATOR  ?= verilator
TOP        ?= tb_display_top
RTL_TOP    ?= display_top
FLIST      ?= sources.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
